//--- rtl/spi_pkg.sv
package spi_pkg;

  // serial byte
  localparam int BYTE_WIDTH = 8;

  typedef logic [BYTE_WIDTH-1:0] spi_byte_t;

  // counts the eight bits of one byte
  localparam int BIT_COUNT_WIDTH = 3;

  // sclk runs at clk/2, so two clk cycles per bit
  localparam int BYTE_CYCLES = 2 * BYTE_WIDTH;

endpackage

//--- rtl/regs_pkg.sv
package regs_pkg;

  localparam int REG_COUNT  = 16;
  localparam int ADDR_WIDTH = $clog2(REG_COUNT);

  typedef logic [ADDR_WIDTH-1:0] reg_addr_t;

  // write flag sits in bit 7 of the command byte, address in bits 3..0, the rest is zero
  localparam int CMD_WRITE_BIT = 7;

  typedef struct packed {
    logic               write;
    reg_addr_t          addr;
    spi_pkg::spi_byte_t wdata;
  } reg_cmd_t;

  typedef struct packed {
    reg_addr_t          addr;
    spi_pkg::spi_byte_t rdata;  // value before the access
  } reg_resp_t;

  // two bytes of start + shift + finish, data relaunch and response stage
  localparam int FRAME_CYCLES = 2 * (spi_pkg::BYTE_CYCLES + 2) + 2;

  function automatic spi_pkg::spi_byte_t make_cmd_byte(input logic write,
                                                       input reg_addr_t addr);
    spi_pkg::spi_byte_t b;
    b = '0;
    b[CMD_WRITE_BIT] = write;
    b[ADDR_WIDTH-1:0] = addr;
    return b;
  endfunction

endpackage

//--- rtl/spi_cmd_issuer.sv
`timescale 1ns/1ps

module spi_cmd_issuer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cmd_valid,
  input  regs_pkg::reg_cmd_t  cmd,
  output logic                busy,
  output logic                byte_start,
  output spi_pkg::spi_byte_t  tx_byte,
  output logic                frame_end,
  input  logic                byte_done,
  output logic                frame_start,
  output regs_pkg::reg_addr_t frame_addr
);
  import regs_pkg::*;

  typedef enum logic [1:0] {IDLE, CMD_BYTE, DATA_BYTE} state_t;

  state_t   state;
  reg_cmd_t cmd_q;
  logic     accept;
  logic     data_start;  // launches the second byte

  assign accept      = (state == IDLE) && cmd_valid;
  assign busy        = (state != IDLE);
  assign frame_start = accept;
  assign frame_addr  = cmd.addr;
  assign byte_start  = accept || data_start;
  assign frame_end   = (state == DATA_BYTE);  // last byte of the frame

  // command byte goes out straight from the strobe, data byte from the latch
  assign tx_byte = (state == IDLE) ? make_cmd_byte(cmd.write, cmd.addr) :
                   (cmd_q.write ? cmd_q.wdata : '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      data_start <= 1'b0;
    end else begin
      data_start <= 1'b0;
      case (state)
        IDLE: begin
          if (cmd_valid) begin
            state <= CMD_BYTE;
          end
        end
        CMD_BYTE: begin
          if (byte_done) begin
            state      <= DATA_BYTE;
            data_start <= 1'b1;
          end
        end
        DATA_BYTE: begin
          if (byte_done) begin
            state <= IDLE;  // busy drops with the response
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
  end

endmodule

//--- rtl/spi_master.sv
`timescale 1ns/1ps

module spi_master (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               byte_start,
  input  spi_pkg::spi_byte_t tx_byte,
  input  logic               frame_end,
  output logic               byte_done,
  output spi_pkg::spi_byte_t rx_byte,
  output logic               sclk,
  output logic               mosi,
  output logic               ss_n,
  input  logic               miso
);
  import spi_pkg::*;

  typedef enum logic [1:0] {IDLE, TRANSMIT, FINISH} state_t;

  state_t                     state;
  state_t                     next_state;
  spi_byte_t                  tx_shift;
  spi_byte_t                  rx_shift;
  logic [BIT_COUNT_WIDTH-1:0] bit_cnt;
  logic                       start_ok;
  logic                       last_byte;  // release ss_n after this byte

  assign start_ok = (state == IDLE) && byte_start;
  assign mosi     = tx_shift[BYTE_WIDTH-1];
  assign rx_byte  = rx_shift;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (byte_start) begin
          next_state = TRANSMIT;
        end
      end
      TRANSMIT: begin
        if (sclk && bit_cnt == '1) begin
          next_state = FINISH;  // eighth falling edge
        end
      end
      FINISH: next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  // toggles every clk while shifting, rests low
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk <= 1'b0;
    end else if (state == TRANSMIT) begin
      sclk <= ~sclk;
    end else begin
      sclk <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start_ok) begin
      tx_shift <= tx_byte;
    end else if (state == TRANSMIT && sclk) begin
      tx_shift <= {tx_shift[BYTE_WIDTH-2:0], 1'b0};  // falling sclk
    end
  end

  always_ff @(posedge clk) begin
    if (state == TRANSMIT && !sclk) begin
      rx_shift <= {rx_shift[BYTE_WIDTH-2:0], miso};  // rising sclk
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '0;
    end else if (start_ok) begin
      bit_cnt <= '0;
    end else if (state == TRANSMIT && sclk) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // chip select spans every byte of a frame
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ss_n      <= 1'b1;
      byte_done <= 1'b0;
      last_byte <= 1'b0;
    end else begin
      byte_done <= (state == FINISH);
      if (start_ok) begin
        ss_n      <= 1'b0;
        last_byte <= frame_end;
      end else if (state == FINISH && last_byte) begin
        ss_n <= 1'b1;
      end
    end
  end

endmodule

//--- rtl/spi_reg_slave.sv
`timescale 1ns/1ps

module spi_reg_slave (
  input  logic clk,
  input  logic rst_n,
  input  logic sclk,
  input  logic mosi,
  input  logic ss_n,
  output logic miso
);
  import spi_pkg::*;
  import regs_pkg::*;

  spi_byte_t                  regs [REG_COUNT];
  spi_byte_t                  rx_shift;
  spi_byte_t                  rx_next;
  spi_byte_t                  tx_shift;
  logic [BIT_COUNT_WIDTH-1:0] bit_cnt;
  logic                       sclk_q;
  logic                       ss_n_q;
  logic                       sclk_rise;
  logic                       ss_n_rise;
  logic                       cmd_seen;   // command byte taken
  logic                       data_seen;  // data byte complete
  logic                       cmd_take;
  logic                       wr_flag;
  reg_addr_t                  addr_q;

  // sclk comes from a clk register, so edges show up one clk later here
  assign sclk_rise = sclk && !sclk_q;
  assign ss_n_rise = ss_n && !ss_n_q;
  assign rx_next   = {rx_shift[BYTE_WIDTH-2:0], mosi};
  assign cmd_take  = !ss_n && sclk_rise && !cmd_seen && bit_cnt == '1;
  assign miso      = tx_shift[BYTE_WIDTH-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_q <= 1'b0;
      ss_n_q <= 1'b1;
    end else begin
      sclk_q <= sclk;
      ss_n_q <= ss_n;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_shift  <= '0;
      bit_cnt   <= '0;
      cmd_seen  <= 1'b0;
      data_seen <= 1'b0;
    end else if (ss_n) begin
      rx_shift  <= '0;  // deselected
      bit_cnt   <= '0;
      cmd_seen  <= 1'b0;
      data_seen <= 1'b0;
    end else if (sclk_rise) begin
      rx_shift <= rx_next;
      bit_cnt  <= bit_cnt + 1'b1;
      if (bit_cnt == '1) begin
        cmd_seen  <= 1'b1;
        data_seen <= cmd_seen;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_flag <= 1'b0;
      addr_q  <= '0;
    end else if (cmd_take) begin
      wr_flag <= rx_next[CMD_WRITE_BIT];
      addr_q  <= rx_next[ADDR_WIDTH-1:0];
    end
  end

  // the shift on the detected rise lands with the falling sclk
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_shift <= '0;
    end else if (ss_n) begin
      tx_shift <= '0;
    end else if (cmd_take) begin
      tx_shift <= regs[rx_next[ADDR_WIDTH-1:0]];  // old value for byte two
    end else if (sclk_rise) begin
      tx_shift <= {tx_shift[BYTE_WIDTH-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (ss_n_rise && wr_flag && data_seen) begin
      regs[addr_q] <= rx_shift;
    end
  end

endmodule

//--- rtl/spi_resp_collector.sv
`timescale 1ns/1ps

module spi_resp_collector (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                frame_start,
  input  regs_pkg::reg_addr_t frame_addr,
  input  logic                byte_done,
  input  spi_pkg::spi_byte_t  rx_byte,
  output logic                resp_valid,
  output regs_pkg::reg_resp_t resp
);
  import regs_pkg::*;

  reg_addr_t addr_q;
  logic      second_byte;  // next byte_done ends the frame

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      second_byte <= 1'b0;
      resp_valid  <= 1'b0;
    end else begin
      resp_valid <= byte_done && second_byte;
      if (frame_start) begin
        second_byte <= 1'b0;
      end else if (byte_done) begin
        second_byte <= ~second_byte;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (frame_start) begin
      addr_q <= frame_addr;
    end
    if (byte_done && second_byte) begin
      resp.addr  <= addr_q;
      resp.rdata <= rx_byte;  // old register value
    end
  end

endmodule

//--- rtl/spi_link_top.sv
`timescale 1ns/1ps

module spi_link_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cmd_valid,
  input  regs_pkg::reg_cmd_t  cmd,
  output logic                busy,
  output logic                resp_valid,
  output regs_pkg::reg_resp_t resp
);
  import spi_pkg::*;
  import regs_pkg::*;

  logic      byte_start;
  logic      byte_done;
  logic      frame_end;
  logic      frame_start;
  reg_addr_t frame_addr;
  spi_byte_t tx_byte;
  spi_byte_t rx_byte;
  logic      sclk;
  logic      mosi;
  logic      miso;
  logic      ss_n;

  spi_cmd_issuer i_issuer (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .busy        (busy),
    .byte_start  (byte_start),
    .tx_byte     (tx_byte),
    .frame_end   (frame_end),
    .byte_done   (byte_done),
    .frame_start (frame_start),
    .frame_addr  (frame_addr)
  );

  spi_master i_master (
    .clk        (clk),
    .rst_n      (rst_n),
    .byte_start (byte_start),
    .tx_byte    (tx_byte),
    .frame_end  (frame_end),
    .byte_done  (byte_done),
    .rx_byte    (rx_byte),
    .sclk       (sclk),
    .mosi       (mosi),
    .ss_n       (ss_n),
    .miso       (miso)
  );

  spi_reg_slave i_slave (
    .clk   (clk),
    .rst_n (rst_n),
    .sclk  (sclk),
    .mosi  (mosi),
    .ss_n  (ss_n),
    .miso  (miso)
  );

  spi_resp_collector i_collector (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_start (frame_start),
    .frame_addr  (frame_addr),
    .byte_done   (byte_done),
    .rx_byte     (rx_byte),
    .resp_valid  (resp_valid),
    .resp        (resp)
  );

endmodule

//--- sim/tb_spi_link.sv
`timescale 1ns/1ps

module tb_spi_link;
  import spi_pkg::*;
  import regs_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RAND_CMDS  = 200;
  localparam int NUM_CMDS   = REG_COUNT + 2 + RAND_CMDS + 2;
  localparam int RESP_LIMIT = 2 * FRAME_CYCLES;  // give up on a response after this

  logic      clk;
  logic      rst_n;
  logic      cmd_valid;
  reg_cmd_t  cmd;
  logic      busy;
  logic      resp_valid;
  reg_resp_t resp;

  spi_byte_t   model [REG_COUNT];  // expected register contents
  reg_resp_t   exp_q [$];
  logic [31:0] rng;
  int          value_errors;
  int          other_errors;

  spi_link_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // every command runs back to back, so the whole run fits in this
  initial begin
    #((NUM_CMDS + 4) * FRAME_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d frame times, the run did not complete",
             NUM_CMDS + 4);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic reg_cmd_t build_cmd(input logic write, input reg_addr_t addr,
                                         input spi_byte_t wdata);
    reg_cmd_t c;
    c.write = write;
    c.addr  = addr;
    c.wdata = wdata;
    return c;
  endfunction

  // old value comes back, then the write lands in the model
  function automatic reg_resp_t ref_access(input reg_cmd_t c);
    reg_resp_t r;
    r.addr  = c.addr;
    r.rdata = model[c.addr];
    if (c.write) begin
      model[c.addr] = c.wdata;
    end
    return r;
  endfunction

  task automatic check_resp(input reg_resp_t got, input reg_resp_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got addr %h data %h, expected addr %h data %h",
               $time, what, got.addr, got.rdata, exp.addr, exp.rdata);
      value_errors++;
    end
  endtask

  task automatic check_busy(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s got busy %b, expected %b", $time, what, got, exp);
      value_errors++;
    end
  endtask

  // one command per frame; drop_at > 0 fires a second strobe mid-frame
  task automatic issue_cmd(input reg_cmd_t c, input int drop_at, input reg_cmd_t drop_cmd);
    int k;
    bit seen;
    cmd_valid = 1'b1;
    cmd       = c;
    exp_q.push_back(ref_access(c));
    k    = 0;
    seen = 1'b0;
    while (!seen && k < RESP_LIMIT) begin
      @(negedge clk);
      k++;
      cmd_valid = 1'b0;
      if (k == drop_at) begin
        cmd_valid = 1'b1;  // frame still busy here
        cmd       = drop_cmd;
      end
      if (resp_valid) begin
        seen = 1'b1;
        if (k != FRAME_CYCLES) begin
          $display("[ERROR] %0t ns: response after %0d cycles, expected %0d",
                   $time, k, FRAME_CYCLES);
          value_errors++;
        end
        check_busy(busy, 1'b0, "busy with response");
      end else begin
        check_busy(busy, 1'b1, "busy during frame");
      end
    end
    if (!seen) begin
      $display("no response for the command to address %h within %0d cycles",
               c.addr, RESP_LIMIT);
      other_errors++;
    end
  endtask

  always @(negedge clk) begin
    if (resp_valid) begin
      if (exp_q.size() == 0) begin
        $display("response for address %h arrived at %0t ns with no command pending",
                 resp.addr, $time);
        other_errors++;
      end else begin
        check_resp(resp, exp_q.pop_front(), "response");
      end
    end
  end

  initial begin
    rst_n        = 1'b0;
    cmd_valid    = 1'b0;
    cmd          = '0;
    rng          = 32'h4ee0bca8;
    value_errors = 0;
    other_errors = 0;
    for (int i = 0; i < REG_COUNT; i++) begin
      model[i] = '0;
    end
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // registers come out of reset as zero
    for (int i = 0; i < REG_COUNT; i++) begin
      issue_cmd(build_cmd(1'b0, reg_addr_t'(i), '0), 0, '0);
    end

    issue_cmd(build_cmd(1'b1, 4'h6, 8'ha5), 0, '0);
    issue_cmd(build_cmd(1'b0, 4'h6, 8'h00), 0, '0);

    repeat (RAND_CMDS) begin
      rng = xorshift32(rng);
      issue_cmd(build_cmd(rng[0], rng[7:4], rng[15:8]), 0, '0);
    end

    // strobe while busy must not reach register 9
    issue_cmd(build_cmd(1'b1, 4'h3, 8'h5a), 10, build_cmd(1'b1, 4'h9, ~model[9]));
    issue_cmd(build_cmd(1'b0, 4'h9, 8'h00), 0, '0);

    repeat (4) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      other_errors++;
    end
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- project.f
rtl/spi_pkg.sv
rtl/regs_pkg.sv
rtl/spi_cmd_issuer.sv
rtl/spi_master.sv
rtl/spi_reg_slave.sv
rtl/spi_resp_collector.sv
rtl/spi_link_top.sv
sim/tb_spi_link.sv
